// ==== design/rv_pkg.sv ====
package rv_pkg;

  localparam int xlen = 32;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011
  } opcode_e;

  // Zero is add, so a bubble decodes to a harmless add
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {
    fwd_reg_file,
    fwd_from_mem,
    fwd_from_wb
  } fwd_sel_e;

  typedef enum logic [1:0] {
    wb_alu,
    wb_load,
    wb_link
  } wb_sel_e;

  // All zero means bubble
  typedef struct packed {
    alu_op_e alu_op;
    logic    use_pc_a;
    logic    use_imm_b;
    logic    branch;
    logic    jump;
    logic    jalr;
    logic    mem_read;
    logic    mem_write;
    logic    reg_write;
    wb_sel_e wb_sel;
  } ctrl_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] imm;
    logic [2:0]      func3;
    ctrl_t           ctrl;
  } id_ex_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [4:0]      rd;
    logic [xlen-1:0] alu_res;
    logic [xlen-1:0] store_data;
    ctrl_t           ctrl;
  } ex_mem_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [4:0]      rd;
    logic [xlen-1:0] alu_res;
    logic [xlen-1:0] load_data;
    ctrl_t           ctrl;
  } mem_wb_t;

  typedef struct packed {
    logic            read;
    logic            write;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
  } mem_req_t;

endpackage

// ==== design/rv_decode.sv ====
`timescale 1ns/1ns

module rv_decode (
  input  logic [rv_pkg::xlen-1:0] instr,
  output rv_pkg::ctrl_t           ctrl,
  output logic [4:0]              rs1,
  output logic [4:0]              rs2,
  output logic [4:0]              rd,
  output logic [rv_pkg::xlen-1:0] imm,
  output logic [2:0]              func3
);

  import rv_pkg::*;

  opcode_e opcode;

  // Shared by register and immediate forms
  function automatic alu_op_e alu_from_func3(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? alu_sub : alu_add;
      3'b001:  op = alu_sll;
      3'b010:  op = alu_slt;
      3'b011:  op = alu_sltu;
      3'b100:  op = alu_xor;
      3'b101:  op = alt ? alu_sra : alu_srl;
      3'b110:  op = alu_or;
      default: op = alu_and;
    endcase
    return op;
  endfunction

  assign opcode = opcode_e'(instr[6:0]);
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];
  assign func3  = instr[14:12];

  always_comb begin
    ctrl = '0;
    imm  = '0;
    case (opcode)
      opc_op: begin
        ctrl.alu_op    = alu_from_func3(func3, instr[30]);
        ctrl.reg_write = 1'b1;
      end
      opc_op_imm: begin
        // Bit 30 is part of the immediate except for the right shifts
        ctrl.alu_op    = alu_from_func3(func3, instr[30] && (func3 == 3'b101));
        ctrl.use_imm_b = 1'b1;
        ctrl.reg_write = 1'b1;
        imm            = {{20{instr[31]}}, instr[31:20]};
      end
      opc_lui: begin
        ctrl.alu_op    = alu_pass_b;
        ctrl.use_imm_b = 1'b1;
        ctrl.reg_write = 1'b1;
        imm            = {instr[31:12], 12'b0};
      end
      opc_auipc: begin
        ctrl.use_pc_a  = 1'b1;
        ctrl.use_imm_b = 1'b1;
        ctrl.reg_write = 1'b1;
        imm            = {instr[31:12], 12'b0};
      end
      opc_jal: begin
        ctrl.jump      = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = wb_link;
        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      opc_jalr: begin
        ctrl.jump      = 1'b1;
        ctrl.jalr      = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = wb_link;
        imm            = {{20{instr[31]}}, instr[31:20]};
      end
      opc_branch: begin
        ctrl.branch = 1'b1;
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      opc_load: begin
        ctrl.use_imm_b = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = wb_load;
        imm            = {{20{instr[31]}}, instr[31:20]};
      end
      opc_store: begin
        ctrl.use_imm_b = 1'b1;
        ctrl.mem_write = 1'b1;
        imm            = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

endmodule

// ==== design/rv_regfile.sv ====
`timescale 1ns/1ns

module rv_regfile (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    we,
  input  logic [4:0]              waddr,
  input  logic [rv_pkg::xlen-1:0] wdata,
  input  logic [4:0]              raddr_a,
  input  logic [4:0]              raddr_b,
  output logic [rv_pkg::xlen-1:0] rdata_a,
  output logic [rv_pkg::xlen-1:0] rdata_b
);

  import rv_pkg::*;

  // x0 has no storage
  logic [xlen-1:0] regs [1:31];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  // Same-cycle write is visible to decode
  assign rdata_a = (raddr_a == 5'd0) ? '0 :
                   (we && (waddr == raddr_a)) ? wdata : regs[raddr_a];
  assign rdata_b = (raddr_b == 5'd0) ? '0 :
                   (we && (waddr == raddr_b)) ? wdata : regs[raddr_b];

endmodule

// ==== design/rv_hazard.sv ====
`timescale 1ns/1ns

module rv_hazard (
  input  logic             [4:0] rs1_ex,
  input  logic             [4:0] rs2_ex,
  input  logic             [4:0] rs1_id,
  input  logic             [4:0] rs2_id,
  input  logic             [4:0] rd_ex,
  input  logic                   load_ex,
  input  logic             [4:0] rd_mem,
  input  logic                   wr_mem,
  input  logic             [4:0] rd_wb,
  input  logic                   wr_wb,
  output rv_pkg::fwd_sel_e       fwd_a,
  output rv_pkg::fwd_sel_e       fwd_b,
  output logic                   stall
);

  import rv_pkg::*;

  // Younger producer wins
  function automatic fwd_sel_e fwd_pick(input logic [4:0] rs);
    fwd_sel_e sel;
    if (wr_mem && (rd_mem != 5'd0) && (rd_mem == rs)) begin
      sel = fwd_from_mem;
    end else if (wr_wb && (rd_wb != 5'd0) && (rd_wb == rs)) begin
      sel = fwd_from_wb;
    end else begin
      sel = fwd_reg_file;
    end
    return sel;
  endfunction

  assign fwd_a = fwd_pick(rs1_ex);
  assign fwd_b = fwd_pick(rs2_ex);

  // Load data is not ready until the memory stage
  assign stall = load_ex && (rd_ex != 5'd0) &&
                 ((rd_ex == rs1_id) || (rd_ex == rs2_id));

endmodule

// ==== design/rv_execute.sv ====
`timescale 1ns/1ns

module rv_execute (
  input  rv_pkg::id_ex_t          id_ex,
  input  rv_pkg::fwd_sel_e        fwd_a,
  input  rv_pkg::fwd_sel_e        fwd_b,
  input  logic [rv_pkg::xlen-1:0] mem_fwd,
  input  logic [rv_pkg::xlen-1:0] wb_fwd,
  output logic [rv_pkg::xlen-1:0] alu_res,
  output logic [rv_pkg::xlen-1:0] store_data,
  output logic                    branch_taken,
  output logic [rv_pkg::xlen-1:0] target
);

  import rv_pkg::*;

  logic [xlen-1:0] rs1_val;
  logic [xlen-1:0] rs2_val;
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] jalr_sum;
  logic            cond;

  function automatic logic [xlen-1:0] fwd_mux(input fwd_sel_e sel,
                                               input logic [xlen-1:0] reg_val);
    logic [xlen-1:0] val;
    case (sel)
      fwd_from_mem: val = mem_fwd;
      fwd_from_wb:  val = wb_fwd;
      default:      val = reg_val;
    endcase
    return val;
  endfunction

  assign rs1_val    = fwd_mux(fwd_a, id_ex.rs1_data);
  assign rs2_val    = fwd_mux(fwd_b, id_ex.rs2_data);
  assign store_data = rs2_val;

  assign op_a = id_ex.ctrl.use_pc_a ? id_ex.pc : rs1_val;
  assign op_b = id_ex.ctrl.use_imm_b ? id_ex.imm : rs2_val;

  always_comb begin
    case (id_ex.ctrl.alu_op)
      alu_add:    alu_res = op_a + op_b;
      alu_sub:    alu_res = op_a - op_b;
      alu_sll:    alu_res = op_a << op_b[4:0];
      alu_slt:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
      alu_sltu:   alu_res = {31'b0, op_a < op_b};
      alu_xor:    alu_res = op_a ^ op_b;
      alu_srl:    alu_res = op_a >> op_b[4:0];
      alu_sra:    alu_res = $unsigned($signed(op_a) >>> op_b[4:0]);
      alu_or:     alu_res = op_a | op_b;
      alu_and:    alu_res = op_a & op_b;
      alu_pass_b: alu_res = op_b;
      default:    alu_res = '0;
    endcase
  end

  // Branch conditions by func3
  always_comb begin
    case (id_ex.func3)
      3'b000:  cond = (rs1_val == rs2_val);
      3'b001:  cond = (rs1_val != rs2_val);
      3'b100:  cond = ($signed(rs1_val) < $signed(rs2_val));
      3'b101:  cond = ($signed(rs1_val) >= $signed(rs2_val));
      3'b110:  cond = (rs1_val < rs2_val);
      3'b111:  cond = (rs1_val >= rs2_val);
      default: cond = 1'b0;
    endcase
  end

  assign branch_taken = id_ex.ctrl.jump || (id_ex.ctrl.branch && cond);

  // jalr target has bit 0 cleared
  assign jalr_sum = rs1_val + id_ex.imm;
  assign target   = id_ex.ctrl.jalr ? {jalr_sum[xlen-1:1], 1'b0} : id_ex.pc + id_ex.imm;

endmodule

// ==== design/rv_pipeline.sv ====
`timescale 1ns/1ns

module rv_pipeline #(
  parameter logic [31:0] reset_pc = 32'h0000_0000
) (
  input  logic                    clk,
  input  logic                    rst_n,
  output logic [rv_pkg::xlen-1:0] pc_addr,
  input  logic [rv_pkg::xlen-1:0] instr,
  output rv_pkg::mem_req_t        mem_req,
  input  logic [rv_pkg::xlen-1:0] load_data
);

  import rv_pkg::*;

  logic [xlen-1:0] pc;
  logic [xlen-1:0] if_instr;
  logic [xlen-1:0] if_pc;
  id_ex_t          id_ex;
  ex_mem_t         ex_mem;
  mem_wb_t         mem_wb;

  ctrl_t           id_ctrl;
  logic [4:0]      id_rs1;
  logic [4:0]      id_rs2;
  logic [4:0]      id_rd;
  logic [xlen-1:0] id_imm;
  logic [2:0]      id_func3;
  logic [xlen-1:0] rf_rdata_a;
  logic [xlen-1:0] rf_rdata_b;

  fwd_sel_e        fwd_a;
  fwd_sel_e        fwd_b;
  logic            stall;
  logic            flush;
  logic [xlen-1:0] ex_alu_res;
  logic [xlen-1:0] ex_store_data;
  logic [xlen-1:0] ex_target;
  logic [xlen-1:0] wb_data;
  logic            rf_we;

  assign pc_addr = pc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else if (flush) begin
      pc <= ex_target;
    end else if (!stall) begin
      pc <= pc + 32'd4;
    end
  end

  // A zero instruction decodes as a bubble
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_instr <= '0;
      if_pc    <= '0;
    end else if (flush) begin
      if_instr <= '0;
    end else if (!stall) begin
      if_instr <= instr;
      if_pc    <= pc;
    end
  end

  rv_decode i_rv_decode (
    .instr (if_instr),
    .ctrl  (id_ctrl),
    .rs1   (id_rs1),
    .rs2   (id_rs2),
    .rd    (id_rd),
    .imm   (id_imm),
    .func3 (id_func3)
  );

  rv_regfile i_rv_regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .we      (rf_we),
    .waddr   (mem_wb.rd),
    .wdata   (wb_data),
    .raddr_a (id_rs1),
    .raddr_b (id_rs2),
    .rdata_a (rf_rdata_a),
    .rdata_b (rf_rdata_b)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex <= '0;
    end else if (flush || stall) begin
      id_ex <= '0;
    end else begin
      id_ex <= '{pc: if_pc, rs1: id_rs1, rs2: id_rs2, rd: id_rd, rs1_data: rf_rdata_a,
                 rs2_data: rf_rdata_b, imm: id_imm, func3: id_func3, ctrl: id_ctrl};
    end
  end

  rv_hazard i_rv_hazard (
    .rs1_ex  (id_ex.rs1),
    .rs2_ex  (id_ex.rs2),
    .rs1_id  (id_rs1),
    .rs2_id  (id_rs2),
    .rd_ex   (id_ex.rd),
    .load_ex (id_ex.ctrl.mem_read),
    .rd_mem  (ex_mem.rd),
    .wr_mem  (ex_mem.ctrl.reg_write),
    .rd_wb   (mem_wb.rd),
    .wr_wb   (mem_wb.ctrl.reg_write),
    .fwd_a   (fwd_a),
    .fwd_b   (fwd_b),
    .stall   (stall)
  );

  rv_execute i_rv_execute (
    .id_ex        (id_ex),
    .fwd_a        (fwd_a),
    .fwd_b        (fwd_b),
    .mem_fwd      (ex_mem.alu_res),
    .wb_fwd       (wb_data),
    .alu_res      (ex_alu_res),
    .store_data   (ex_store_data),
    .branch_taken (flush),
    .target       (ex_target)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_mem <= '0;
      mem_wb <= '0;
    end else begin
      ex_mem <= '{pc: id_ex.pc, rd: id_ex.rd, alu_res: ex_alu_res,
                  store_data: ex_store_data, ctrl: id_ex.ctrl};
      mem_wb <= '{pc: ex_mem.pc, rd: ex_mem.rd, alu_res: ex_mem.alu_res,
                  load_data: load_data, ctrl: ex_mem.ctrl};
    end
  end

  assign mem_req = '{read: ex_mem.ctrl.mem_read, write: ex_mem.ctrl.mem_write,
                     addr: ex_mem.alu_res, wdata: ex_mem.store_data};

  // Writeback select
  always_comb begin
    case (mem_wb.ctrl.wb_sel)
      wb_load: wb_data = mem_wb.load_data;
      wb_link: wb_data = mem_wb.pc + 32'd4;
      default: wb_data = mem_wb.alu_res;
    endcase
  end

  assign rf_we = mem_wb.ctrl.reg_write && (mem_wb.rd != 5'd0);

endmodule

// ==== tb/rv_pipeline_chk.sv ====
`timescale 1ns/1ns

module rv_pipeline_chk (
  input logic                    clk,
  input logic                    rst_n,
  input logic [rv_pkg::xlen-1:0] pc_addr,
  input rv_pkg::mem_req_t        mem_req,
  input logic                    stall,
  input logic                    flush
);

  import rv_pkg::*;

  int fail_count = 0;

  pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc_addr[1:0] == 2'b00)
    else begin
      $error("pc_addr is not word aligned");
      fail_count++;
    end

  req_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
                                  !(mem_req.read && mem_req.write))
    else begin
      $error("mem_req read and write are active together");
      fail_count++;
    end

  // Load-use bubble keeps the fetch address
  stall_holds_pc: assert property (@(posedge clk) disable iff (!rst_n)
                                   stall |=> pc_addr == $past(pc_addr))
    else begin
      $error("pc_addr moved during a stall");
      fail_count++;
    end

  pc_steps: assert property (@(posedge clk) disable iff (!rst_n)
                             !stall && !flush |=> pc_addr == $past(pc_addr) + 32'd4)
    else begin
      $error("pc_addr did not advance by one word");
      fail_count++;
    end

  idle_after_reset: assert property (@(posedge clk)
                                     $rose(rst_n) |-> !mem_req.read && !mem_req.write)
    else begin
      $error("mem_req active in the first cycle after reset");
      fail_count++;
    end

endmodule

bind rv_pipeline rv_pipeline_chk i_rv_pipeline_chk (
  .clk     (clk),
  .rst_n   (rst_n),
  .pc_addr (pc_addr),
  .mem_req (mem_req),
  .stall   (stall),
  .flush   (flush)
);

// ==== tb/rv_pipeline_tb.sv ====
`timescale 1ns/1ns

module rv_pipeline_tb;

  import rv_pkg::*;

  localparam logic [31:0] reset_pc  = 32'h0000_1000;
  localparam logic [31:0] nop_word  = 32'h0000_0013;
  localparam logic [6:0]  op_imm    = 7'b0010011;
  localparam logic [31:0] load_addr = 32'h0000_01f0;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
  } store_t;

  logic        clk = 1'b0;
  logic        rst_n = 1'b0;
  logic [31:0] pc_addr;
  logic [31:0] instr;
  mem_req_t    mem_req;
  logic [31:0] load_data;
  logic [31:0] fetch_off;

  logic [31:0] imem [0:127];
  logic [31:0] dmem [0:127];
  // Expected architectural register values
  logic [31:0] xv [0:31];
  store_t      exp_q [$];
  int          prog_len = 0;
  int          slot = 0;
  int          pending = 0;
  int          loads_seen = 0;
  int          seed = 56514;
  logic        built = 1'b0;

  always #10 clk = ~clk;

  rv_pipeline #(.reset_pc(reset_pc)) i_rv_pipeline (
    .clk       (clk),
    .rst_n     (rst_n),
    .pc_addr   (pc_addr),
    .instr     (instr),
    .mem_req   (mem_req),
    .load_data (load_data)
  );

  assign fetch_off = pc_addr - reset_pc;
  assign instr     = (fetch_off < 32'd512) ? imem[fetch_off[8:2]] : nop_word;
  assign load_data = dmem[mem_req.addr[8:2]];

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5aa5_c33c;
  endfunction

  // RV32I integer rules
  function automatic logic [31:0] alu_expect(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
    int sa;
    int sb;
    sa = a;
    sb = b;
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, sa < sb};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? 32'(sa >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_expect(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
    int sa;
    int sb;
    sa = a;
    sb = b;
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return sa < sb;
      3'd5:    return sa >= sb;
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic void emit(input logic [31:0] word);
    imem[prog_len] = word;
    prog_len++;
  endfunction

  // Each store gets its own word address
  function automatic void add_store(input logic [4:0] rs, input logic expect_it);
    store_t s;
    s.addr = 32'(slot * 4);
    s.data = xv[rs];
    emit(s_type(s.addr[11:0], rs, 5'd0));
    slot++;
    if (expect_it) begin
      exp_q.push_back(s);
    end
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp)
      else abort_run($sformatf("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp));
  endtask

  task automatic build_program();
    logic [11:0] imm;
    logic [31:0] a;
    logic [31:0] pc_now;
    logic [2:0]  f3;
    logic        alt;
    logic [4:0]  ra;
    logic [4:0]  rb;
    for (int i = 0; i < 128; i++) begin
      imem[i] = nop_word;
      dmem[i] = fill_word(32'(i * 4));
    end
    for (int i = 0; i < 32; i++) begin
      xv[i] = '0;
    end
    for (int r = 1; r <= 2; r++) begin
      imm = 12'($random(seed));
      emit(i_type(imm, 5'd0, 3'd0, 5'(r), op_imm));
      xv[r] = sext12(imm);
    end
    // x2 comes from memory stage, x1 from writeback
    emit(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
    xv[3] = xv[1] + xv[2];
    emit(r_type(7'h20, 5'd1, 5'd3, 3'd0, 5'd4));
    xv[4] = xv[3] - xv[1];
    // Store of x4 sees writes to x4 in both memory and writeback
    emit(r_type(7'h00, 5'd3, 5'd4, 3'd4, 5'd4));
    xv[4] = xv[4] ^ xv[3];
    add_store(5'd4, 1'b1);
    add_store(5'd3, 1'b1);
    for (int k = 0; k < 10; k++) begin
      f3  = (k < 8) ? k[2:0] : ((k == 8) ? 3'd0 : 3'd5);
      alt = (k >= 8);
      emit(r_type(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd5));
      xv[5] = alu_expect(f3, alt, xv[1], xv[2]);
      add_store(5'd5, 1'b1);
    end
    for (int k = 0; k < 9; k++) begin
      imm = 12'($random(seed));
      f3  = (k < 8) ? k[2:0] : 3'd5;
      alt = (k == 8);
      if (f3 == 3'd1 || f3 == 3'd5) begin
        imm = {1'b0, alt, 5'b0, imm[4:0]};
      end
      emit(i_type(imm, 5'd1, f3, 5'd6, op_imm));
      xv[6] = alu_expect(f3, alt, xv[1], sext12(imm));
      add_store(5'd6, 1'b1);
    end
    a = $random(seed);
    emit(u_type(a[19:0], 5'd7, 7'b0110111));
    xv[7] = {a[19:0], 12'b0};
    add_store(5'd7, 1'b1);
    pc_now = reset_pc + 32'(prog_len * 4);
    emit(u_type(a[31:12], 5'd8, 7'b0010111));
    xv[8] = pc_now + {a[31:12], 12'b0};
    add_store(5'd8, 1'b1);
    // Load then immediate use
    emit(i_type(load_addr[11:0], 5'd0, 3'b010, 5'd9, 7'b0000011));
    xv[9] = fill_word(load_addr);
    emit(r_type(7'h00, 5'd1, 5'd9, 3'd0, 5'd10));
    xv[10] = xv[9] + xv[1];
    add_store(5'd10, 1'b1);
    // Each condition with swapped and equal operands
    for (int c = 0; c < 6; c++) begin
      f3 = (c < 2) ? c[2:0] : c[2:0] + 3'd2;
      for (int p = 0; p < 3; p++) begin
        ra = (p == 1) ? 5'd2 : 5'd1;
        rb = (p == 0) ? 5'd2 : 5'd1;
        alt = branch_expect(f3, xv[ra], xv[rb]);
        emit(b_type(13'd12, rb, ra, f3));
        add_store(5'd3, !alt);
        add_store(5'd4, !alt);
      end
    end
    pc_now = reset_pc + 32'(prog_len * 4);
    emit(j_type(21'd12, 5'd11));
    xv[11] = pc_now + 32'd4;
    add_store(5'd3, 1'b0);
    add_store(5'd4, 1'b0);
    add_store(5'd11, 1'b1);
    // Odd jalr offset, bit 0 of the target is dropped
    pc_now = reset_pc + 32'(prog_len * 4);
    emit(u_type(20'd0, 5'd12, 7'b0010111));
    xv[12] = pc_now;
    emit(i_type(12'd17, 5'd12, 3'd0, 5'd13, 7'b1100111));
    xv[13] = pc_now + 32'd8;
    add_store(5'd3, 1'b0);
    add_store(5'd4, 1'b0);
    add_store(5'd13, 1'b1);
    imm = 12'($random(seed));
    imm[0] = 1'b1;
    emit(i_type(imm, 5'd0, 3'd0, 5'd0, op_imm));
    add_store(5'd0, 1'b1);
    pending = exp_q.size();
    built   = 1'b1;
  endtask

  // Bus checks mid-cycle, memory write on the edge
  always @(negedge clk) begin
    if (rst_n && mem_req.read) begin
      check_word("mem_req.addr", mem_req.addr, load_addr);
      loads_seen++;
    end
    if (rst_n && mem_req.write) begin
      assert (exp_q.size() != 0)
        else abort_run("a store appeared on mem_req after the last expected store");
      if (exp_q.size() != 0) begin
        check_word("mem_req.addr", mem_req.addr, exp_q[0].addr);
        check_word("mem_req.wdata", mem_req.wdata, exp_q[0].data);
        void'(exp_q.pop_front());
        pending--;
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n && mem_req.write) begin
      dmem[mem_req.addr[8:2]] <= mem_req.wdata;
    end
  end

  initial begin
    wait (i_rv_pipeline.i_rv_pipeline_chk.fail_count != 0);
    abort_run("a bound assertion on the DUT failed");
  end

  initial begin
    wait (built);
    repeat (prog_len * 10) @(posedge clk);
    abort_run("timeout: the program did not finish in time");
  end

  initial begin
    build_program();
    repeat (5) @(posedge clk);
    check_word("pc_addr", pc_addr, reset_pc);
    @(negedge clk);
    rst_n = 1'b1;
    wait (pending == 0);
    repeat (4) @(posedge clk);
    check_word("load count", 32'(loads_seen), 32'd1);
    if (i_rv_pipeline.i_rv_pipeline_chk.fail_count == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      abort_run("a bound assertion on the DUT failed");
    end
  end

endmodule

// ==== compile.f ====
design/rv_pkg.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_hazard.sv
design/rv_execute.sv
design/rv_pipeline.sv
tb/rv_pipeline_chk.sv
tb/rv_pipeline_tb.sv

// ==== Bender.yml ====
package:
  name: rv_pipeline

sources:
  - files:
      - design/rv_pkg.sv
      - design/rv_decode.sv
      - design/rv_regfile.sv
      - design/rv_hazard.sv
      - design/rv_execute.sv
      - design/rv_pipeline.sv
  - target: test
    files:
      - tb/rv_pipeline_chk.sv
      - tb/rv_pipeline_tb.sv
